// File: testbench/dispatch_patterns.txt
# rst fv u0 rd0 rs1_0 rs2_0 u1 rd1 rs1_1 rs2_1 rs_free retire exp_count exp_stall
# one line per clock cycle, all decimal, fv is fetch_valid as 0..3
# both slots write, tags come out from 32
0 3 1 1 2 3 1 4 5 6 3 0 2 0
# slot 1 reads and rewrites slot 0 rd
0 3 1 7 1 4 1 7 7 1 3 0 2 0
0 3 1 9 7 7 0 0 9 9 3 0 2 0
# one RS slot left, slot 1 comes back alone
0 3 1 10 1 2 1 11 10 3 1 0 1 1
0 1 1 11 10 3 0 0 0 0 1 0 1 0
# fill the ROB to 15 with non-writers
0 3 0 0 1 2 0 0 3 4 3 0 2 0
0 3 0 0 5 6 0 0 7 8 3 0 2 0
0 3 0 0 9 10 0 0 11 12 3 0 2 0
0 1 0 0 1 1 0 0 0 0 3 0 1 0
# one ROB entry left
0 3 1 12 1 1 1 13 2 2 3 0 1 1
# ROB full, retire makes room for the next cycle
0 1 1 13 2 2 0 0 0 0 3 1 0 1
0 1 1 13 2 2 0 0 0 0 3 0 1 0
# drain in program order, writers hand back their old tag
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
# ROB fills before the free list can drain, tag limit never binds
# use up tags 41..63, tag 1 comes back last
0 3 1 2 1 4 1 3 2 7 3 1 2 0
0 3 1 5 3 9 1 6 5 5 3 1 2 0
0 3 1 8 2 6 1 14 8 11 3 1 2 0
0 3 1 15 14 1 1 16 15 15 3 1 2 0
0 3 1 17 16 0 1 18 17 4 3 1 2 0
0 3 1 19 18 18 1 20 19 20 3 1 2 0
0 3 1 21 20 3 1 22 21 22 3 1 2 0
0 3 1 23 22 2 1 24 23 24 3 1 2 0
0 3 1 25 24 5 1 26 25 26 3 1 2 0
0 3 1 27 26 8 1 28 27 28 3 1 2 0
0 3 1 29 28 30 1 30 29 30 3 1 2 0
0 3 1 31 30 31 1 1 31 1 3 1 2 0
# reset in mid-run, then identity map and a fresh free list
1 0 0 0 0 0 0 0 0 0 3 0 0 0
0 0 0 0 0 0 0 0 0 0 3 1 0 0
0 3 1 1 4 7 1 2 1 0 3 0 2 0
0 3 1 4 1 2 1 1 4 2 3 1 2 0

// File: tb.f
+incdir+hw
hw/dispatch_pkg.sv
hw/ring_queue.sv
hw/rename_map.sv
hw/dispatch_ctrl.sv
hw/dispatch_subsys.sv
testbench/dispatch_properties.sv
testbench/tb_dispatch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dispatch testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_dispatch -o tb_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/tb_dispatch.sv
/*
 * Testbench for the rename and dispatch top level.
 * Pattern file reader, clock and reset, reference rename model
 * (map, free list, ROB), per-cycle output checks, watchdog.
 */

`include "dispatch_consts.svh"

module tb_dispatch;

    import dispatch_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;

    // pattern columns
    localparam int NCOL    = 14;
    localparam int C_RST   = 0;
    localparam int C_FV    = 1;
    localparam int C_SLOT0 = 2;
    localparam int C_RS    = 10;
    localparam int C_RET   = 11;
    localparam int C_CNT   = 12;
    localparam int C_STALL = 13;

    logic                          clock;
    logic                          arst_n;
    logic [`DISP_WIDTH-1:0]        fetch_valid;
    logic [`DISP_WIDTH-1:0]        uses_rd;
    arch_reg_t [`DISP_WIDTH-1:0]   rd_idx;
    arch_reg_t [`DISP_WIDTH-1:0]   rs1_idx;
    arch_reg_t [`DISP_WIDTH-1:0]   rs2_idx;
    logic [2:0]                    rs_free_slots;
    logic                          retire_en;
    slot_cnt_t                     dispatch_count;
    logic                          stall_fetch;
    logic [`DISP_WIDTH-1:0]        disp_valid;
    phys_tag_t [`DISP_WIDTH-1:0]   rs1_phys;
    phys_tag_t [`DISP_WIDTH-1:0]   rs2_phys;
    phys_tag_t [`DISP_WIDTH-1:0]   rd_phys;
    phys_tag_t [`DISP_WIDTH-1:0]   prev_rd_phys;
    logic                          retire_valid;
    arch_reg_t                     retire_arch_rd;
    phys_tag_t                     retire_phys_rd;
    logic [$clog2(`FREE_SZ+1)-1:0] free_tag_count;

    // rows flattened into NCOL fields each
    int   pat_q[$];
    int   num_rows;
    logic rows_loaded;
    int   value_errors;
    int   other_errors;

    // reference model state
    int         map_m [`ARCH_REGS];
    int         free_m[$];
    rob_entry_t rob_m[$];

    // model predictions for the current cycle
    logic [`DISP_WIDTH-1:0] exp_go;
    int                     exp_tag  [`DISP_WIDTH];
    int                     exp_rs1  [`DISP_WIDTH];
    int                     exp_rs2  [`DISP_WIDTH];
    int                     exp_prev [`DISP_WIDTH];
    logic                   exp_retire;

    dispatch_subsys dispatch_subsys_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .fetch_valid    (fetch_valid),
        .uses_rd        (uses_rd),
        .rd_idx         (rd_idx),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs_free_slots  (rs_free_slots),
        .retire_en      (retire_en),
        .dispatch_count (dispatch_count),
        .stall_fetch    (stall_fetch),
        .disp_valid     (disp_valid),
        .rs1_phys       (rs1_phys),
        .rs2_phys       (rs2_phys),
        .rd_phys        (rd_phys),
        .prev_rd_phys   (prev_rd_phys),
        .retire_valid   (retire_valid),
        .retire_arch_rd (retire_arch_rd),
        .retire_phys_rd (retire_phys_rd),
        .free_tag_count (free_tag_count)
    );

    initial begin
        clock = 1'b0;
    end

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // pattern file
    ////////////////////////////////////////////////////////////////////////////

    function automatic int pattern_value(input int row, input int col);
        return pat_q[row * NCOL + col];
    endfunction

    // lines starting with # are column notes
    task automatic load_patterns(output bit ok);
        int    fd;
        int    n;
        string line;
        int    v [NCOL];
        ok       = 1'b0;
        num_rows = 0;
        fd = $fopen("testbench/dispatch_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                                v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
                    if (n == NCOL) begin
                        for (int k = 0; k < NCOL; k++) begin
                            pat_q.push_back(v[k]);
                        end
                        num_rows++;
                    end else begin
                        other_errors++;
                        $display("pattern line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
            ok = (num_rows > 0);
        end
    endtask

    // slot fields sit four apart from C_SLOT0
    task automatic apply_row(input int r);
        int base;
        arst_n        = (pattern_value(r, C_RST) == 0);
        fetch_valid   = 2'(pattern_value(r, C_FV));
        rs_free_slots = 3'(pattern_value(r, C_RS));
        retire_en     = (pattern_value(r, C_RET) != 0);
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            base       = C_SLOT0 + 4 * i;
            uses_rd[i] = (pattern_value(r, base) != 0);
            rd_idx[i]  = arch_reg_t'(pattern_value(r, base + 1));
            rs1_idx[i] = arch_reg_t'(pattern_value(r, base + 2));
            rs2_idx[i] = arch_reg_t'(pattern_value(r, base + 3));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        for (int r = 0; r < `ARCH_REGS; r++) begin
            map_m[r] = r;
        end
        free_m.delete();
        for (int t = `ARCH_REGS; t < `PHYS_REGS; t++) begin
            free_m.push_back(t);
        end
        rob_m.delete();
    endtask

    // in-order prefix with each slot charged on top of the ones before it
    task automatic predict_slots();
        int   rob_room;
        int   tags_left;
        int   taken;
        logic chain_ok;
        rob_room  = `ROB_SZ - rob_m.size();
        tags_left = free_m.size();
        taken     = 0;
        chain_ok  = 1'b1;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            chain_ok = chain_ok && fetch_valid[i]
                    && (rob_room >= i + 1)
                    && (int'(rs_free_slots) >= i + 1)
                    && (!uses_rd[i] || (tags_left >= taken + 1));
            exp_go[i] = chain_ok;
            if (chain_ok && uses_rd[i]) begin
                exp_tag[i] = free_m[taken];
                taken++;
            end else begin
                exp_tag[i] = 0;
            end
            exp_rs1[i]  = map_m[rs1_idx[i]];
            exp_rs2[i]  = map_m[rs2_idx[i]];
            exp_prev[i] = map_m[rd_idx[i]];
        end
        // slot 1 sees slot 0's new tag
        if (uses_rd[0] && exp_go[0]) begin
            if (rs1_idx[1] == rd_idx[0]) begin
                exp_rs1[1] = exp_tag[0];
            end
            if (rs2_idx[1] == rd_idx[0]) begin
                exp_rs2[1] = exp_tag[0];
            end
            if (rd_idx[1] == rd_idx[0]) begin
                exp_prev[1] = exp_tag[0];
            end
        end
        exp_retire = retire_en && (rob_m.size() > 0);
    endtask

    // retire, then allocate and update the map at the clock edge
    task automatic advance_model();
        rob_entry_t head;
        rob_entry_t ent;
        logic       give_back;
        give_back = 1'b0;
        head      = '0;
        if (exp_retire) begin
            head      = rob_m.pop_front();
            give_back = head.uses_rd;
        end
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            if (exp_go[i]) begin
                ent.uses_rd      = uses_rd[i];
                ent.arch_rd      = rd_idx[i];
                ent.phys_rd      = phys_tag_t'(exp_tag[i]);
                ent.prev_phys_rd = phys_tag_t'(exp_prev[i]);
                rob_m.push_back(ent);
                if (uses_rd[i]) begin
                    free_m.delete(0);
                    map_m[rd_idx[i]] = exp_tag[i];
                end
            end
        end
        // freed tag lands behind the remaining free tags
        if (give_back) begin
            free_m.push_back(int'(head.prev_phys_rd));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input int got, input int expected);
        assert (got == expected)
        else begin
            value_errors++;
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_outputs(input int r);
        compare_value("dispatch_count", int'(dispatch_count), pattern_value(r, C_CNT));
        compare_value("stall_fetch", int'(stall_fetch), pattern_value(r, C_STALL));
        compare_value("disp_valid", int'(disp_valid), int'(exp_go));
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            if (exp_go[i]) begin
                compare_value($sformatf("rs1_phys[%0d]", i), int'(rs1_phys[i]), exp_rs1[i]);
                compare_value($sformatf("rs2_phys[%0d]", i), int'(rs2_phys[i]), exp_rs2[i]);
                compare_value($sformatf("rd_phys[%0d]", i), int'(rd_phys[i]), exp_tag[i]);
                compare_value($sformatf("prev_rd_phys[%0d]", i), int'(prev_rd_phys[i]),
                              exp_prev[i]);
            end
        end
        compare_value("free_tag_count", int'(free_tag_count), free_m.size());
        compare_value("retire_valid", int'(retire_valid), int'(exp_retire));
        if (exp_retire) begin
            compare_value("retire_arch_rd", int'(retire_arch_rd), int'(rob_m[0].arch_rd));
            compare_value("retire_phys_rd", int'(retire_phys_rd), int'(rob_m[0].phys_rd));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        bit loaded_ok;
        int property_errors;
        arst_n        = 1'b0;
        fetch_valid   = '0;
        uses_rd       = '0;
        rd_idx        = '0;
        rs1_idx       = '0;
        rs2_idx       = '0;
        rs_free_slots = '0;
        retire_en     = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        rows_loaded   = 1'b0;
        reset_model();
        load_patterns(loaded_ok);
        if (!loaded_ok) begin
            $display("pattern file missing or holds no usable lines");
            $display("TEST FAILED");
            $finish;
        end else begin
            rows_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clock);
            for (int r = 0; r < num_rows; r++) begin
                #1;
                apply_row(r);
                if (pattern_value(r, C_RST) != 0) begin
                    reset_model();
                end
                predict_slots();
                // sample shortly before the next edge
                #(CLK_PERIOD - 3);
                check_outputs(r);
                if (pattern_value(r, C_RST) == 0) begin
                    advance_model();
                end
                @(posedge clock);
            end
            // bound property checks of the last edge settle first
            #1;
            property_errors = dispatch_subsys_inst.dispatch_properties_inst.failures;
            $display("errors: %0d value mismatches, %0d property, %0d other failures",
                     value_errors, property_errors, other_errors);
            if (value_errors + property_errors + other_errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // watchdog allows one cycle per row plus margin for reset
    initial begin
        wait (rows_loaded);
        #((num_rows + 20) * CLK_PERIOD);
        $display("timeout: the pattern run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: testbench/dispatch_properties.sv
/*
 * Concurrent checks bound into the dispatch top level.
 * Count bounded by valid slots, stall consistency,
 * in-order slot dispatch, running count of failed checks.
 */

`include "dispatch_consts.svh"

module dispatch_properties (
    input logic                    clock,
    input logic                    arst_n,
    input logic [`DISP_WIDTH-1:0]  fetch_valid,
    input dispatch_pkg::slot_cnt_t dispatch_count,
    input logic                    stall_fetch,
    input logic [`DISP_WIDTH-1:0]  disp_valid
);

    // failed checks per property
    int count_fails = 0;
    int stall_fails = 0;
    int order_fails = 0;
    int failures;

    assign failures = count_fails + stall_fails + order_fails;

    // never more than fetch offered
    count_within_valid: assert property (
        @(posedge clock) disable iff (!arst_n)
        int'(dispatch_count) <= $countones(fetch_valid)
    ) else begin
        count_fails = count_fails + 1;
        $error("dispatch_count exceeds the number of valid slots");
    end

    // stall only with leftovers
    stall_means_leftover: assert property (
        @(posedge clock) disable iff (!arst_n)
        stall_fetch |-> (int'(dispatch_count) < $countones(fetch_valid))
    ) else begin
        stall_fails = stall_fails + 1;
        $error("stall_fetch high with the whole bundle dispatched");
    end

    // prefix order
    slot1_needs_slot0: assert property (
        @(posedge clock) disable iff (!arst_n)
        disp_valid[1] |-> disp_valid[0]
    ) else begin
        order_fails = order_fails + 1;
        $error("slot 1 dispatched without slot 0");
    end

endmodule

bind dispatch_subsys dispatch_properties dispatch_properties_inst (
    .clock          (clock),
    .arst_n         (arst_n),
    .fetch_valid    (fetch_valid),
    .dispatch_count (dispatch_count),
    .stall_fetch    (stall_fetch),
    .disp_valid     (disp_valid)
);

// File: hw/dispatch_subsys.sv
/*
 * Rename and dispatch top level.
 * Dispatch control, map table, free list and ROB queues,
 * tag steering for the bundle, single-wide retire back to the free list.
 */

`include "dispatch_consts.svh"

module dispatch_subsys (
    input  logic                                       clock,
    input  logic                                       arst_n,
    // fetch bundle
    input  logic [`DISP_WIDTH-1:0]                     fetch_valid,
    input  logic [`DISP_WIDTH-1:0]                     uses_rd,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rd_idx,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rs1_idx,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rs2_idx,
    input  logic [2:0]                                 rs_free_slots,
    input  logic                                       retire_en,
    // dispatch side
    output dispatch_pkg::slot_cnt_t                    dispatch_count,
    output logic                                       stall_fetch,
    output logic [`DISP_WIDTH-1:0]                     disp_valid,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] rs1_phys,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] rs2_phys,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] rd_phys,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] prev_rd_phys,
    // retire side
    output logic                                       retire_valid,
    output dispatch_pkg::arch_reg_t                    retire_arch_rd,
    output dispatch_pkg::phys_tag_t                    retire_phys_rd,
    output logic [$clog2(`FREE_SZ+1)-1:0]              free_tag_count
);

    import dispatch_pkg::*;

    localparam int unsigned ROB_CW = $clog2(`ROB_SZ + 1);

    logic [`DISP_WIDTH-1:0]    slot_go;
    logic [`DISP_WIDTH-1:0]    tag_alloc;
    phys_tag_t [1:0]           free_head;
    phys_tag_t [1:0]           new_tag;
    slot_cnt_t                 free_pop;
    logic [1:0]                free_push_en;
    phys_tag_t [1:0]           free_push_data;
    logic [$clog2(`FREE_SZ+1)-1:0] free_count;

    rob_entry_t [1:0]          rob_push;
    rob_entry_t [1:0]          rob_head;
    logic [ROB_CW-1:0]         rob_count;
    logic [ROB_CW-1:0]         rob_free;
    logic                      retire_fire;

    ////////////////////////////////////////////////////////////////////////////
    // dispatch decision
    ////////////////////////////////////////////////////////////////////////////

    // retire in the same cycle is not counted as ROB space
    assign rob_free = ROB_CW'(`ROB_SZ) - rob_count;

    dispatch_ctrl dispatch_ctrl_inst (
        .fetch_valid    (fetch_valid),
        .uses_rd        (uses_rd),
        .rob_free       (rob_free),
        .rs_free_slots  (rs_free_slots),
        .free_tags      (free_count),
        .slot_go        (slot_go),
        .dispatch_count (dispatch_count),
        .stall_fetch    (stall_fetch)
    );

    assign disp_valid = slot_go;

    // tag steering, slot 1 takes head+1 only behind a writing slot 0
    assign tag_alloc  = slot_go & uses_rd;
    assign new_tag[0] = free_head[0];
    assign new_tag[1] = tag_alloc[0] ? free_head[1] : free_head[0];
    assign free_pop   = slot_cnt_t'(tag_alloc[0]) + slot_cnt_t'(tag_alloc[1]);

    // zero tag on slots that take none
    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            rd_phys[i] = tag_alloc[i] ? new_tag[i] : '0;
        end
    end

    rename_map rename_map_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .slot_go      (slot_go),
        .uses_rd      (uses_rd),
        .rd_idx       (rd_idx),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .new_tag      (new_tag),
        .rs1_phys     (rs1_phys),
        .rs2_phys     (rs2_phys),
        .prev_rd_phys (prev_rd_phys)
    );

    ////////////////////////////////////////////////////////////////////////////
    // free list and ROB
    ////////////////////////////////////////////////////////////////////////////

    // tags above the arch range start out free
    ring_queue #(
        .payload_t  (phys_tag_t),
        .DEPTH      (`FREE_SZ),
        .RESET_FILL (`PHYS_REGS - `ARCH_REGS),
        .FILL_BASE  (`ARCH_REGS)
    ) free_list (
        .clock     (clock),
        .arst_n    (arst_n),
        .push_en   (free_push_en),
        .push_data (free_push_data),
        .pop_cnt   (free_pop),
        .head_data (free_head),
        .count     (free_count)
    );

    assign free_tag_count = free_count;

    // one ROB entry per dispatched slot
    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            rob_push[i].uses_rd      = uses_rd[i];
            rob_push[i].arch_rd      = rd_idx[i];
            rob_push[i].phys_rd      = rd_phys[i];
            rob_push[i].prev_phys_rd = prev_rd_phys[i];
        end
    end

    // head+1 read port of the ROB is left idle, one retire per cycle
    ring_queue #(
        .payload_t (rob_entry_t),
        .DEPTH     (`ROB_SZ)
    ) rob_queue (
        .clock     (clock),
        .arst_n    (arst_n),
        .push_en   (slot_go),
        .push_data (rob_push),
        .pop_cnt   (slot_cnt_t'(retire_fire)),
        .head_data (rob_head),
        .count     (rob_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // retire
    ////////////////////////////////////////////////////////////////////////////

    assign retire_fire    = retire_en && (rob_count != '0);
    assign retire_valid   = retire_fire;
    assign retire_arch_rd = rob_head[0].arch_rd;
    assign retire_phys_rd = rob_head[0].phys_rd;

    // old mapping of a retiring writer goes back on lane 0
    assign free_push_en      = {1'b0, retire_fire && rob_head[0].uses_rd};
    assign free_push_data[0] = rob_head[0].prev_phys_rd;
    assign free_push_data[1] = '0;

endmodule

// File: hw/dispatch_ctrl.sv
/*
 * Dispatch decision for one bundle.
 * In-order prefix check against ROB, RS and free-tag space,
 * per-slot go signals, dispatch count and fetch stall.
 */

`include "dispatch_consts.svh"

module dispatch_ctrl (
    input  logic [`DISP_WIDTH-1:0]        fetch_valid,
    input  logic [`DISP_WIDTH-1:0]        uses_rd,
    input  logic [$clog2(`ROB_SZ+1)-1:0]  rob_free,
    input  logic [2:0]                    rs_free_slots,
    input  logic [$clog2(`FREE_SZ+1)-1:0] free_tags,
    output logic [`DISP_WIDTH-1:0]        slot_go,
    output dispatch_pkg::slot_cnt_t       dispatch_count,
    output logic                          stall_fetch
);

    import dispatch_pkg::*;

    localparam int unsigned ROB_CW = $clog2(`ROB_SZ + 1);
    localparam int unsigned TAG_CW = $clog2(`FREE_SZ + 1);

    // running demand up to and including the current slot
    slot_cnt_t need_slots;
    slot_cnt_t need_tags;
    logic      prefix_ok;

    // valid instructions offered by fetch
    slot_cnt_t valid_count;

    ////////////////////////////////////////////////////////////////////////////
    // prefix rule
    ////////////////////////////////////////////////////////////////////////////

    // fetch keeps leftovers packed from slot 0,
    // an invalid slot 0 dispatches nothing
    always_comb begin
        need_slots = '0;
        need_tags  = '0;
        prefix_ok  = 1'b1;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            need_slots = need_slots + slot_cnt_t'(1);
            need_tags  = need_tags + slot_cnt_t'(uses_rd[i]);
            // ROB and RS take one entry per slot,
            // tags only for writers
            prefix_ok  = prefix_ok
                      && fetch_valid[i]
                      && (rob_free >= ROB_CW'(need_slots))
                      && (rs_free_slots >= 3'(need_slots))
                      && (!uses_rd[i] || (free_tags >= TAG_CW'(need_tags)));
            slot_go[i] = prefix_ok;
        end
    end

    // counts
    always_comb begin
        valid_count    = '0;
        dispatch_count = '0;
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            valid_count    = valid_count + slot_cnt_t'(fetch_valid[i]);
            dispatch_count = dispatch_count + slot_cnt_t'(slot_go[i]);
        end
    end

    // hold fetch while part of the bundle is left over
    assign stall_fetch = (valid_count > dispatch_count);

endmodule

// File: hw/rename_map.sv
/*
 * Speculative register map table.
 * Source and old-destination lookup for both slots,
 * slot 0 to slot 1 bypass, destination writes at the clock.
 */

`include "dispatch_consts.svh"

module rename_map (
    input  logic                                       clock,
    input  logic                                       arst_n,
    input  logic [`DISP_WIDTH-1:0]                     slot_go,
    input  logic [`DISP_WIDTH-1:0]                     uses_rd,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rd_idx,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rs1_idx,
    input  dispatch_pkg::arch_reg_t [`DISP_WIDTH-1:0] rs2_idx,
    input  dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] new_tag,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] rs1_phys,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] rs2_phys,
    output dispatch_pkg::phys_tag_t [`DISP_WIDTH-1:0] prev_rd_phys
);

    import dispatch_pkg::*;

    // arch -> phys, speculative view
    phys_tag_t map_q [`ARCH_REGS];

    // slots that commit a destination this cycle
    logic [`DISP_WIDTH-1:0] map_wr;

    // slot 0 destination hits for slot 1
    logic hit_rs1;
    logic hit_rs2;
    logic hit_rd;

    assign map_wr = slot_go & uses_rd;

    assign hit_rs1 = uses_rd[0] && (rs1_idx[1] == rd_idx[0]);
    assign hit_rs2 = uses_rd[0] && (rs2_idx[1] == rd_idx[0]);
    assign hit_rd  = uses_rd[0] && (rd_idx[1] == rd_idx[0]);

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // table read, both slots
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            rs1_phys[i]     = map_q[rs1_idx[i]];
            rs2_phys[i]     = map_q[rs2_idx[i]];
            prev_rd_phys[i] = map_q[rd_idx[i]];
        end
        // slot 1 sees slot 0's rename, table is one cycle behind
        if (hit_rs1) begin
            rs1_phys[1] = new_tag[0];
        end
        if (hit_rs2) begin
            rs2_phys[1] = new_tag[0];
        end
        // WAW in the bundle, slot 1 frees slot 0's tag later
        if (hit_rd) begin
            prev_rd_phys[1] = new_tag[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // identity, r -> p r
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else begin
            // later slot wins on same rd
            for (int i = 0; i < `DISP_WIDTH; i++) begin
                if (map_wr[i]) begin
                    map_q[rd_idx[i]] <= new_tag[i];
                end
            end
        end
    end

endmodule

// File: hw/ring_queue.sv
/*
 * Circular queue with two write ports and a variable pop.
 * Up to two pushes per cycle into consecutive slots, pop of 0..2
 * entries from the head, head and head+1 readable every cycle.
 * Optional preload of RESET_FILL entries counting up from FILL_BASE.
 */

module ring_queue #(
    parameter type         payload_t  = logic [7:0],
    parameter int unsigned DEPTH      = 16,
    parameter int unsigned RESET_FILL = 0,
    parameter int unsigned FILL_BASE  = 0
) (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic [1:0]                 push_en,
    input  payload_t [1:0]             push_data,
    input  dispatch_pkg::slot_cnt_t    pop_cnt,
    output payload_t [1:0]             head_data,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    // DEPTH is a power of two, pointers wrap on their own
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // write port signals
    logic             wr0_en;
    logic             wr1_en;
    logic [PTR_W-1:0] wr0_addr;
    logic [PTR_W-1:0] wr1_addr;
    payload_t         wr0_data;
    payload_t         wr1_data;
    logic [CNT_W-1:0] push_n;

    ////////////////////////////////////////////////////////////////////////////
    // push packing
    ////////////////////////////////////////////////////////////////////////////

    // a lone push on lane 1 still lands at the tail
    assign wr0_en   = |push_en;
    assign wr1_en   = &push_en;
    assign wr0_addr = tail_q;
    assign wr1_addr = tail_q + PTR_W'(1);
    assign wr0_data = push_en[0] ? push_data[0] : push_data[1];
    assign wr1_data = push_data[1];
    assign push_n   = CNT_W'(push_en[0]) + CNT_W'(push_en[1]);

    // read side, head and the one behind it
    assign head_nxt     = head_q + PTR_W'(1);
    assign head_data[0] = mem[head_q];
    assign head_data[1] = mem[head_nxt];
    assign count        = count_q;

    // pointers and occupancy
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= PTR_W'(RESET_FILL);
            count_q <= CNT_W'(RESET_FILL);
        end else begin
            head_q  <= head_q + PTR_W'(pop_cnt);
            tail_q  <= tail_q + PTR_W'(push_n);
            count_q <= count_q + push_n - CNT_W'(pop_cnt);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    generate
        if (RESET_FILL > 0) begin : g_fill
            // preloaded storage, entry i = FILL_BASE + i
            // entries past RESET_FILL are never read before a write
            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[i] <= payload_t'(FILL_BASE + i);
                    end
                end else begin
                    if (wr0_en) begin
                        mem[wr0_addr] <= wr0_data;
                    end
                    if (wr1_en) begin
                        mem[wr1_addr] <= wr1_data;
                    end
                end
            end
        end else begin : g_plain
            // plain storage, starts empty
            always_ff @(posedge clock) begin
                if (wr0_en) begin
                    mem[wr0_addr] <= wr0_data;
                end
                if (wr1_en) begin
                    mem[wr1_addr] <= wr1_data;
                end
            end
        end
    endgenerate

endmodule

// File: hw/dispatch_pkg.sv
/*
 * Shared types for rename and dispatch.
 * Register indices, physical tags, the ROB entry layout
 * and the small per-bundle slot count.
 */

`include "dispatch_consts.svh"

package dispatch_pkg;

    // architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;

    // one reorder buffer entry
    // prev_phys_rd goes back to the free list at retire
    typedef struct packed {
        logic      uses_rd;
        arch_reg_t arch_rd;
        phys_tag_t phys_rd;
        phys_tag_t prev_phys_rd;
    } rob_entry_t;

    // 0 .. DISP_WIDTH
    typedef logic [$clog2(`DISP_WIDTH+1)-1:0] slot_cnt_t;

endpackage

// File: hw/dispatch_consts.svh
/*
 * Sizing constants for the rename and dispatch subsystem.
 * Bundle width, register file sizes, ROB depth, free-list capacity.
 */

`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// instructions per fetch bundle
`define DISP_WIDTH 2

// architectural register count
`define ARCH_REGS 32

// physical register count
`define PHYS_REGS 64

// reorder buffer entries
`define ROB_SZ 16

// free list capacity, sized to hold every physical tag
`define FREE_SZ `PHYS_REGS

`endif
